//--- src/pipe_trace_pkg.sv
// Shared sizes, record layout and enums for the pipeline trace unit
// Record is packed high to low as seq, fetch stall, decode stall, PC, instruction
// Header trace word holds seq in [23:16], fetch stalls in [15:12], decode stalls in [11:8]
// All other header bits are zero. Stall counters saturate at 15, seq wraps at 256
`default_nettype none

package pipe_trace_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int PC_W        = 32;
  localparam int INSTR_W     = 32;
  localparam int STALL_CNT_W = 4;
  localparam int SEQ_W       = 8;
  localparam int TRACE_W     = 32;               // One trace word on the output port
  localparam logic [STALL_CNT_W-1:0] STALL_MAX = '1; // Saturation point of the counters

  // Record field positions, instruction in the low bits
  localparam int REC_INSTR_LSB = 0;
  localparam int REC_PC_LSB    = REC_INSTR_LSB + INSTR_W;
  localparam int REC_DCNT_LSB  = REC_PC_LSB + PC_W;
  localparam int REC_FCNT_LSB  = REC_DCNT_LSB + STALL_CNT_W;
  localparam int REC_SEQ_LSB   = REC_FCNT_LSB + STALL_CNT_W;
  localparam int REC_W         = REC_SEQ_LSB + SEQ_W; // 80 bits total

  // Header word field positions
  localparam int HDR_DCNT_LSB = 8;
  localparam int HDR_FCNT_LSB = 12;
  localparam int HDR_SEQ_LSB  = 16;

  ////////////////////
  // Pipeline and FIFO
  ////////////////////
  localparam int NUM_STAGES = 5;
  localparam int ST_FE  = 0;   // Fetch
  localparam int ST_DE  = 1;   // Decode
  localparam int ST_EX  = 2;   // Execute
  localparam int ST_MEM = 3;   // Memory
  localparam int ST_WB  = 4;   // Writeback

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;
  localparam int FIFO_CW    = FIFO_AW + 1;   // Occupancy count reaches FIFO_DEPTH

  typedef enum logic [1:0] {TK_NONE, TK_HDR, TK_PC, TK_INSTR} trace_kind_t;
  typedef enum logic [1:0] {SER_IDLE, SER_HDR, SER_PC, SER_INSTR} ser_state_t;

endpackage

`default_nettype wire

//--- src/stage_tracker.sv
// Occupancy model of a five stage in-order pipeline
// A stall holds fetch and decode and pushes a bubble into execute
// Execute, memory and writeback always advance
// fetch_valid is ignored while stall is high
// retire_push is high for every cycle writeback holds a valid entry
`timescale 1ns/1ps
`default_nettype none

module stage_tracker import pipe_trace_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_valid,
  input  logic [PC_W-1:0]    fetch_pc,
  input  logic [INSTR_W-1:0] fetch_instr,
  input  logic               stall,
  output logic               retire_push,
  output logic [REC_W-1:0]   retire_rec
);

  logic [NUM_STAGES-1:0]  vld;                  // Stage occupied
  logic [PC_W-1:0]        pc_q   [NUM_STAGES];
  logic [INSTR_W-1:0]     ins_q  [NUM_STAGES];
  logic [STALL_CNT_W-1:0] fcnt_q [NUM_STAGES];  // Cycles held in fetch
  logic [STALL_CNT_W-1:0] dcnt_q [NUM_STAGES];  // Cycles held in decode
  logic [SEQ_W-1:0]       seq_q;                // Next retirement number
  logic                   accept;

  // Counter stops at 15 so long stalls read as "at least 15"
  function automatic logic [STALL_CNT_W-1:0] sat_inc(input logic [STALL_CNT_W-1:0] c);
    return (c == STALL_MAX) ? c : c + 1'b1;
  endfunction

  assign accept = fetch_valid && !stall;  // New instruction enters fetch

  ////////////////////
  // Valid bits
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      if (!stall) begin
        vld[ST_FE] <= accept;
        vld[ST_DE] <= vld[ST_FE];
        vld[ST_EX] <= vld[ST_DE];
      end else begin
        vld[ST_EX] <= 1'b0;          // Bubble, fetch and decode hold
      end
      vld[ST_MEM] <= vld[ST_EX];     // Back end never stalls
      vld[ST_WB]  <= vld[ST_MEM];
    end
  end

  ////////////////////
  // Stage payload
  ////////////////////
  always_ff @(posedge clk) begin
    if (!stall) begin
      if (accept) begin
        pc_q[ST_FE]   <= fetch_pc;
        ins_q[ST_FE]  <= fetch_instr;
        fcnt_q[ST_FE] <= '0;
        dcnt_q[ST_FE] <= '0;
      end
      // Fetch to decode, stall counts travel with the entry
      pc_q[ST_DE]   <= pc_q[ST_FE];
      ins_q[ST_DE]  <= ins_q[ST_FE];
      fcnt_q[ST_DE] <= fcnt_q[ST_FE];
      dcnt_q[ST_DE] <= dcnt_q[ST_FE];
      // Decode to execute
      pc_q[ST_EX]   <= pc_q[ST_DE];
      ins_q[ST_EX]  <= ins_q[ST_DE];
      fcnt_q[ST_EX] <= fcnt_q[ST_DE];
      dcnt_q[ST_EX] <= dcnt_q[ST_DE];
    end else begin
      // Held entries count the stall cycle in their own stage
      if (vld[ST_FE])
        fcnt_q[ST_FE] <= sat_inc(fcnt_q[ST_FE]);
      if (vld[ST_DE])
        dcnt_q[ST_DE] <= sat_inc(dcnt_q[ST_DE]);
    end

    // Execute to memory to writeback every cycle
    pc_q[ST_MEM]   <= pc_q[ST_EX];
    ins_q[ST_MEM]  <= ins_q[ST_EX];
    fcnt_q[ST_MEM] <= fcnt_q[ST_EX];
    dcnt_q[ST_MEM] <= dcnt_q[ST_EX];
    pc_q[ST_WB]    <= pc_q[ST_MEM];
    ins_q[ST_WB]   <= ins_q[ST_MEM];
    fcnt_q[ST_WB]  <= fcnt_q[ST_MEM];
    dcnt_q[ST_WB]  <= dcnt_q[ST_MEM];
  end

  ////////////////////
  // Retirement
  ////////////////////
  // Seq advances on every push, a dropped record still uses its number
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      seq_q <= '0;
    else if (retire_push)
      seq_q <= seq_q + 1'b1;   // Wraps modulo 256
  end

  assign retire_push = vld[ST_WB];
  assign retire_rec  = {seq_q,
                        fcnt_q[ST_WB],
                        dcnt_q[ST_WB],
                        pc_q[ST_WB],
                        ins_q[ST_WB]};

endmodule

`default_nettype wire

//--- src/retire_fifo.sv
// Show-ahead FIFO for retirement records, head entry always on head_rec
// A push to a full FIFO is dropped unless a pop happens in the same cycle
// A dropped push sets overflow, which stays high until reset
// pop on an empty FIFO is ignored
`timescale 1ns/1ps
`default_nettype none

module retire_fifo import pipe_trace_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [REC_W-1:0] push_rec,
  input  logic             pop,
  output logic [REC_W-1:0] head_rec,
  output logic             empty,
  output logic             overflow
);

  logic [REC_W-1:0]   mem [FIFO_DEPTH];   // Record storage
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count_q;            // Entries held, 0 to FIFO_DEPTH
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (count_q == FIFO_CW'(FIFO_DEPTH));
  assign empty   = (count_q == '0);
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop);  // Pop frees a slot this same edge

  ////////////////////
  // Pointers and count
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count_q  <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;     // Depth is a power of two, wraps by itself
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // Both or neither
      endcase
      if (push && !do_push)
        overflow <= 1'b1;              // Sticky
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_rec;
  end

  assign head_rec = mem[rd_ptr];   // Valid only while empty is low

endmodule

`default_nettype wire

//--- src/trace_serializer.sv
// Turns each record into three trace words, header then PC then instruction
// Output is a plain strobe with no back-pressure
// Next record is popped together with the instruction word, so records run back to back
// trace_valid, trace_kind and trace_data decode from the state register
`timescale 1ns/1ps
`default_nettype none

module trace_serializer import pipe_trace_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               empty,
  input  logic [REC_W-1:0]   head_rec,
  output logic               pop,
  output logic               trace_valid,
  output trace_kind_t        trace_kind,
  output logic [TRACE_W-1:0] trace_data
);

  ser_state_t       state_q;
  ser_state_t       state_nxt;
  logic [REC_W-1:0] rec_q;       // Record being sent
  logic [TRACE_W-1:0] hdr_word;

  // Free to take a record when idle or on the last word of the current one
  assign pop = ((state_q == SER_IDLE) || (state_q == SER_INSTR)) && !empty;

  ////////////////////
  // State machine
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state_q <= SER_IDLE;
    else
      state_q <= state_nxt;
  end

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      SER_IDLE:  if (pop) state_nxt = SER_HDR;
      SER_HDR:   state_nxt = SER_PC;
      SER_PC:    state_nxt = SER_INSTR;
      SER_INSTR: state_nxt = pop ? SER_HDR : SER_IDLE;
      default:   state_nxt = SER_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (pop)
      rec_q <= head_rec;   // Latched on the popping edge
  end

  ////////////////////
  // Output words
  ////////////////////
  always_comb begin
    hdr_word = '0;
    hdr_word[HDR_SEQ_LSB  +: SEQ_W]       = rec_q[REC_SEQ_LSB  +: SEQ_W];
    hdr_word[HDR_FCNT_LSB +: STALL_CNT_W] = rec_q[REC_FCNT_LSB +: STALL_CNT_W];
    hdr_word[HDR_DCNT_LSB +: STALL_CNT_W] = rec_q[REC_DCNT_LSB +: STALL_CNT_W];
  end

  always_comb begin
    trace_valid = 1'b1;
    trace_kind  = TK_NONE;
    trace_data  = '0;
    case (state_q)
      SER_HDR: begin
        trace_kind = TK_HDR;
        trace_data = hdr_word;
      end
      SER_PC: begin
        trace_kind = TK_PC;
        trace_data = rec_q[REC_PC_LSB +: PC_W];
      end
      SER_INSTR: begin
        trace_kind = TK_INSTR;   // Marks the end of a record
        trace_data = rec_q[REC_INSTR_LSB +: INSTR_W];
      end
      default: trace_valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/pipe_trace_top.sv
// Pipeline trace unit, tracker feeds FIFO feeds serializer
// With no stalls an instruction fetched at edge k shows its header after edge k+6
// A burst of retirements faster than one per three cycles overflows the FIFO
// overflow is sticky until rst_n
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_top import pipe_trace_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_valid,
  input  logic [PC_W-1:0]    fetch_pc,
  input  logic [INSTR_W-1:0] fetch_instr,
  input  logic               stall,
  output logic               trace_valid,
  output trace_kind_t        trace_kind,
  output logic [TRACE_W-1:0] trace_data,
  output logic               overflow
);

  // Tracker to FIFO
  logic             retire_push;
  logic [REC_W-1:0] retire_rec;
  // FIFO to serializer
  logic [REC_W-1:0] head_rec;
  logic             empty;
  logic             pop;

  ////////////////////
  // Producer
  ////////////////////
  stage_tracker u_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .stall       (stall),
    .retire_push (retire_push),
    .retire_rec  (retire_rec)
  );

  retire_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (retire_push),
    .push_rec (retire_rec),
    .pop      (pop),
    .head_rec (head_rec),
    .empty    (empty),
    .overflow (overflow)   // Straight to the top port
  );

  ////////////////////
  // Consumer
  ////////////////////
  trace_serializer u_ser (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty       (empty),
    .head_rec    (head_rec),
    .pop         (pop),
    .trace_valid (trace_valid),
    .trace_kind  (trace_kind),
    .trace_data  (trace_data)
  );

endmodule

`default_nettype wire

//--- testbench/pipe_trace_props.sv
// Concurrent checks on the trace port, FIFO occupancy and the overflow flag
// Bound into pipe_trace_top, FIFO count reached through the u_fifo instance
// Every check is disabled while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_props import pipe_trace_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               trace_valid,
  input  trace_kind_t        trace_kind,
  input  logic               overflow,
  input  logic [FIFO_CW-1:0] fifo_count
);

  // One sticky bit per property
  bit   valid_bad  = 1'b0;
  bit   pc_bad     = 1'b0;
  bit   instr_bad  = 1'b0;
  bit   sticky_bad = 1'b0;
  bit   count_bad  = 1'b0;
  logic any_fail;

  assign any_fail = valid_bad | pc_bad | instr_bad | sticky_bad | count_bad;

  ////////////////////
  // Trace port
  ////////////////////
  a_valid_kind: assert property (@(posedge clk) disable iff (!rst_n)
    trace_valid == (trace_kind != TK_NONE))
  else begin
    $error("trace_valid and trace_kind disagree");
    valid_bad = 1'b1;
  end

  a_hdr_then_pc: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_kind == TK_HDR) |=> (trace_kind == TK_PC))   // PC word right after header
  else begin
    $error("Header word not followed by a PC word");
    pc_bad = 1'b1;
  end

  a_pc_then_instr: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_kind == TK_PC) |=> (trace_kind == TK_INSTR))
  else begin
    $error("PC word not followed by an instruction word");
    instr_bad = 1'b1;
  end

  ////////////////////
  // FIFO state
  ////////////////////
  a_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    overflow |=> overflow)   // Only reset clears it
  else begin
    $error("overflow fell without a reset");
    sticky_bad = 1'b1;
  end

  a_fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_count <= FIFO_CW'(FIFO_DEPTH))
  else begin
    $error("FIFO holds more entries than its depth");
    count_bad = 1'b1;
  end

endmodule

bind pipe_trace_top pipe_trace_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .trace_valid (trace_valid),
  .trace_kind  (trace_kind),
  .overflow    (overflow),
  .fifo_count  (u_fifo.count_q)
);

`default_nettype wire

//--- testbench/pipe_trace_tb.sv
// Testbench for pipe_trace_top, inputs change on the rising edge
// Outputs are sampled on the falling edge and checked by immediate assertions
// Expected records come from a model of the fetch and decode stall rule
// Only the burst phase may lose records to FIFO overflow
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_tb import pipe_trace_pkg::*; ();

  localparam int LIMIT = 500;   // Cycles before any wait gives up

  typedef struct packed {
    logic [SEQ_W-1:0]       seq;
    logic [STALL_CNT_W-1:0] fcnt;
    logic [STALL_CNT_W-1:0] dcnt;
    logic [PC_W-1:0]        pc;
    logic [INSTR_W-1:0]     instr;
  } exp_rec_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               fetch_valid;
  logic               stall;
  logic [PC_W-1:0]    fetch_pc;
  logic [INSTR_W-1:0] fetch_instr;
  logic               trace_valid;
  trace_kind_t        trace_kind;
  logic [TRACE_W-1:0] trace_data;
  logic               overflow;

  exp_rec_t     exp_q[$];        // Records past decode, in retire order
  exp_rec_t     cur;             // Record being checked on the trace port
  exp_rec_t     fe_r;
  exp_rec_t     de_r;
  logic         fe_v = 1'b0;
  logic         de_v = 1'b0;
  int           fe_n = 0;        // Stall cycles seen in fetch
  int           de_fn = 0;
  int           de_dn = 0;       // Stall cycles seen in decode
  logic [7:0]   next_seq = '0;
  logic [31:0]  last_hdr = '0;
  int           last_seq = -1;
  int           recs_seen = 0;
  bit           allow_drop = 1'b0;

  always #5 clk = ~clk;   // 10 ns period

  pipe_trace_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .stall       (stall),
    .trace_valid (trace_valid),
    .trace_kind  (trace_kind),
    .trace_data  (trace_data),
    .overflow    (overflow)
  );

  ////////////////////
  // Helpers
  ////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("Error %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
    abort_run("Value check failed");
  endtask

  function automatic logic [STALL_CNT_W-1:0] sat15(input int n);
    return (n > 15) ? 4'd15 : STALL_CNT_W'(n);   // Counters stop at 15
  endfunction

  task automatic drive(input logic fv, input logic st);
    @(posedge clk);
    fetch_valid <= fv;
    stall       <= st;
    fetch_pc    <= $urandom & 32'hffff_fffc;   // Word aligned
    fetch_instr <= $urandom;
  endtask

  task automatic apply_reset(input int cycles);
    @(posedge clk);
    rst_n       <= 1'b0;
    fetch_valid <= 1'b0;
    stall       <= 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      assert (!trace_valid) else mismatch("trace_valid", 32'h0, 32'(trace_valid));
      assert (trace_kind == TK_NONE) else mismatch("trace_kind", 32'h0, 32'(trace_kind));
      assert (!overflow) else mismatch("overflow", 32'h0, 32'(overflow));
      @(posedge clk);
    end
    rst_n      <= 1'b1;
    allow_drop = 1'b0;
    last_seq   = -1;   // Seq restarts at 0
  endtask

  // Idle inputs, then wait until the model and the trace port are empty
  task automatic wait_idle();
    int  t;
    bit  busy;
    drive(1'b0, 1'b0);
    t    = 0;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = (exp_q.size() != 0) || fe_v || de_v || trace_valid;
      if (busy && t >= LIMIT)
        abort_run("Timed out waiting for the trace output to drain");
      else
        t++;
    end
  endtask

  // Burst end, dropped records stay in the model so wait for silence instead
  task automatic wait_quiet();
    int t;
    int quiet;
    drive(1'b0, 1'b0);
    t     = 0;
    quiet = 0;
    while (quiet < 10) begin
      @(negedge clk);
      quiet = (trace_valid || fe_v || de_v) ? 0 : quiet + 1;
      if (quiet < 10 && t >= LIMIT)
        abort_run("Timed out waiting for the burst to leave the trace port");
      else
        t++;
    end
  endtask

  task automatic check_stalls(input int f, input int d);
    assert (last_hdr[15:12] == 4'(f)) else mismatch("trace_data fetch stalls", f, last_hdr[15:12]);
    assert (last_hdr[11:8] == 4'(d)) else mismatch("trace_data decode stalls", d, last_hdr[11:8]);
  endtask

  // Fetch, hold in fetch for n cycles, move once, hold in decode for m cycles
  task automatic stall_case(input int n, input int m);
    drive(1'b1, 1'b0);
    repeat (n) drive(1'b0, 1'b1);
    drive(1'b0, 1'b0);
    repeat (m) drive(1'b0, 1'b1);
    wait_idle();
    check_stalls((n > 15) ? 15 : n, m);
  endtask

  // Two free edges after each fetch keep retirements slower than the serializer
  task automatic random_instr();
    repeat ($urandom_range(3, 0)) drive(1'b0, 1'b1);
    drive(1'b1, 1'b0);
    repeat ($urandom_range(3, 0)) drive(1'b0, 1'b1);
    drive(1'b0, 1'b0);
    repeat ($urandom_range(3, 0)) drive(1'b0, 1'b1);
    drive(1'b0, 1'b0);
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Front end only, a record is final once it leaves decode
  always @(posedge clk or negedge rst_n) begin : model
    exp_rec_t r;
    if (!rst_n) begin
      fe_v     = 1'b0;
      de_v     = 1'b0;
      next_seq = '0;
      exp_q.delete();
    end else if (stall) begin
      if (fe_v)
        fe_n++;
      if (de_v)
        de_dn++;
    end else begin
      if (de_v) begin
        r      = de_r;
        r.fcnt = sat15(de_fn);
        r.dcnt = sat15(de_dn);
        exp_q.push_back(r);
      end
      de_v  = fe_v;
      de_r  = fe_r;
      de_fn = fe_n;
      de_dn = 0;
      fe_v  = fetch_valid;
      if (fetch_valid) begin
        fe_r       = '0;
        fe_r.seq   = next_seq;   // Retire order equals fetch order
        fe_r.pc    = fetch_pc;
        fe_r.instr = fetch_instr;
        fe_n       = 0;
        next_seq   = next_seq + 8'd1;
      end
    end
  end

  ////////////////////
  // Output monitor
  ////////////////////
  always @(negedge clk) begin : monitor
    logic [31:0] exp_hdr;
    int          skipped;
    if (UUT.u_props.any_fail) begin
      abort_run("A concurrent assertion on the DUT failed");
    end else if (rst_n) begin
      assert (allow_drop || !overflow) else mismatch("overflow", 32'h0, 32'(overflow));
      if (trace_valid) begin
        case (trace_kind)
          TK_HDR: begin
            skipped = 0;
            while (allow_drop && exp_q.size() > 0 && exp_q[0].seq != trace_data[23:16]) begin
              void'(exp_q.pop_front());   // Dropped by the FIFO
              skipped++;
            end
            if (exp_q.size() == 0)
              abort_run("Header word has no matching record in the model");
            else if (skipped > 0 && !overflow)
              abort_run("Records were lost while overflow is low");
            else if (int'(trace_data[23:16]) <= last_seq)
              abort_run("Sequence number did not increase");
            else begin
              cur             = exp_q.pop_front();
              last_seq        = int'(cur.seq);
              last_hdr        = trace_data;
              exp_hdr         = '0;
              exp_hdr[23:16]  = cur.seq;
              exp_hdr[15:12]  = cur.fcnt;
              exp_hdr[11:8]   = cur.dcnt;
              assert (trace_data == exp_hdr) else mismatch("trace_data header", exp_hdr, trace_data);
            end
          end
          TK_PC:
            assert (trace_data == cur.pc) else mismatch("trace_data pc", cur.pc, trace_data);
          TK_INSTR: begin
            assert (trace_data == cur.instr) else mismatch("trace_data instr", cur.instr, trace_data);
            recs_seen++;   // End of a record
          end
          default:
            abort_run("trace_valid is high with no trace kind");
        endcase
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin : stimulus
    int base;
    void'($urandom(85577));
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    stall       = 1'b0;
    fetch_pc    = '0;
    fetch_instr = '0;
    apply_reset(4);

    base = recs_seen;   // One instruction, no stall
    drive(1'b1, 1'b0);
    wait_idle();
    assert (recs_seen == base + 1) else mismatch("records seen", base + 1, recs_seen);
    check_stalls(0, 0);

    stall_case(3, 2);
    stall_case(20, 5);   // Fetch count saturates

    base = recs_seen;
    repeat (24) random_instr();
    wait_idle();
    assert (recs_seen == base + 24) else mismatch("records seen", base + 24, recs_seen);

    // Back to back retirements, faster than one record per three cycles
    allow_drop = 1'b1;
    base       = recs_seen;
    repeat (16) drive(1'b1, 1'b0);
    wait_quiet();
    assert (overflow) else mismatch("overflow", 32'h1, 32'(overflow));
    assert (recs_seen > base + 3) else abort_run("Too few records came out of the burst");

    apply_reset(4);   // Clears overflow and seq
    drive(1'b1, 1'b0);
    wait_idle();
    assert (last_hdr[23:16] == 8'h00) else mismatch("trace_data seq", 32'h0, last_hdr[23:16]);

    if (UUT.u_props.any_fail) begin
      abort_run("A concurrent assertion on the DUT failed");
    end else if (exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("Expected records were left unchecked at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- pipe_trace.f
src/pipe_trace_pkg.sv
src/stage_tracker.sv
src/retire_fifo.sv
src/trace_serializer.sv
src/pipe_trace_top.sv
testbench/pipe_trace_props.sv
testbench/pipe_trace_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the pipeline trace testbench with Verilator and runs it
# Exit status is zero only when the simulation ends with $finish

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module pipe_trace_tb \
  -Mdir obj_dir \
  -f pipe_trace.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

# Concurrent assertion errors are counted so the testbench can end the run itself
./obj_dir/Vpipe_trace_tb +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
